// File: Makefile
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module aux_audio_tb -f filelist.f -Mdir $(OBJ_DIR) -o sim
	./$(OBJ_DIR)/sim +verilator+error+limit+100 | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer
  import aux_audio_pkg::*;
(
  input  logic    clk_114,
  input  logic    rst,
  input  sample_t chip_left,
  input  sample_t chip_right,
  input  sample_t aux_left,
  input  sample_t aux_right,
  output sample_t mix_left,
  output sample_t mix_right
);

  logic signed [16:0] sum_left;
  logic signed [16:0] sum_right;

  // Clamp a 17-bit sum to the sample range
  function automatic sample_t clamp(input logic signed [16:0] sum);
    sample_t res;
    if (sum[16] != sum[15]) begin
      res = sum[16] ? 16'sh8000 : 16'sh7fff;  // Overflow in either direction
    end else begin
      res = sum[15:0];
    end
    return res;
  endfunction

  assign sum_left  = 17'(chip_left) + 17'(aux_left);   // Sign extended
  assign sum_right = 17'(chip_right) + 17'(aux_right);

  always_ff @(posedge clk_114) begin
    if (rst) begin
      mix_left  <= '0;
      mix_right <= '0;
    end else begin
      mix_left  <= clamp(sum_left);
      mix_right <= clamp(sum_right);
    end
  end

endmodule

// File: design/audio_stream_ctrl.sv
`timescale 1ns/1ps

module audio_stream_ctrl
  import aux_audio_pkg::*;
(
  input  logic        clk_114,
  input  logic        rst,
  input  logic        enable,
  input  logic        mem_ack,
  input  logic        mem_fill,
  output logic        mem_req,
  output mem_addr_t   mem_addr,
  output logic        buf_half,
  output logic        side_left,
  output logic        pop_strobe,
  stream_fifo_if.ctrl fifo
);

  logic [TICK_W-1:0]    tick_cnt;
  logic [STREAM_AW-1:0] offset;   // Next word to fetch
  logic [LEVEL_W-1:0]   owed;     // Words accepted but not yet filled
  logic                 tick;
  logic                 accept;
  logic [LEVEL_W:0]     pending;
  logic                 room;

  assign tick    = (tick_cnt == TICK_W'(SAMPLE_PERIOD - 1));
  assign accept  = mem_req & mem_ack;
  assign pending = {1'b0, fifo.level} + {1'b0, owed};
  assign room    = (pending <= (LEVEL_W + 1)'(FIFO_DEPTH - BURST_LEN));

  assign mem_addr = {AUD_BASE, offset};
  assign buf_half = offset[STREAM_AW-1];  // Half of the buffer being fetched

  // Pop only when a word is there
  assign pop_strobe = enable & tick & (fifo.level != '0);
  assign fifo.pop   = pop_strobe;
  assign fifo.flush = ~enable;

  ////////////////////
  // Fetch requests
  ////////////////////

  always_ff @(posedge clk_114) begin
    if (rst) begin
      mem_req <= 1'b0;
      offset  <= '0;
    end else if (!enable) begin
      mem_req <= 1'b0;
      offset  <= '0;  // Restart at the buffer base
    end else if (accept) begin
      mem_req <= 1'b0;
      offset  <= offset + STREAM_AW'(BURST_LEN);
    end else if (!mem_req && room) begin
      mem_req <= 1'b1;  // Address is stable until ack
    end
  end

  // Outstanding words keep counting while disabled so late fills balance out
  always_ff @(posedge clk_114) begin
    if (rst) begin
      owed <= '0;
    end else begin
      case ({accept, mem_fill})
        2'b10:   owed <= owed + LEVEL_W'(BURST_LEN);
        2'b11:   owed <= owed + LEVEL_W'(BURST_LEN - 1);
        2'b01:   owed <= owed - 1'b1;
        default: owed <= owed;
      endcase
    end
  end

  ////////////////////
  // Sample pacing
  ////////////////////

  always_ff @(posedge clk_114) begin
    if (rst || !enable) begin
      tick_cnt  <= '0;
      side_left <= 1'b1;  // First pop goes left
    end else begin
      if (tick) begin
        tick_cnt <= '0;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
      if (pop_strobe) begin
        side_left <= ~side_left;  // No toggle on an empty tick
      end
    end
  end

endmodule

// File: design/aux_audio_pkg.sv
package aux_audio_pkg;

  //////////////////////
  // Data types
  //////////////////////

  typedef logic signed [15:0] sample_t;   // One audio word
  typedef logic        [22:0] mem_addr_t; // SDRAM word address

  //////////////////////
  // Sample pacing
  //////////////////////

  // clk_114 cycles between two pops
  localparam int SAMPLE_PERIOD = 2572;
  localparam int TICK_W        = 12;      // Holds SAMPLE_PERIOD - 1

  //////////////////////
  // Fetch and FIFO
  //////////////////////

  localparam int BURST_LEN  = 4;          // Words per accepted request
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = 4;
  localparam int LEVEL_W    = 5;          // Counts 0 to FIFO_DEPTH

  // Stream offset inside the buffer, wraps at 64K words
  localparam int STREAM_AW = 16;

  // Upper address bits of the audio buffer
  localparam logic [6:0] AUD_BASE = 7'b1101111;

endpackage

// File: design/aux_audio_top.sv
`timescale 1ns/1ps

module aux_audio_top
  import aux_audio_pkg::*;
(
  input  logic      clk_114,
  input  logic      rst,
  input  logic      enable,
  input  logic      mem_ack,
  input  logic      mem_fill,
  input  sample_t   mem_data,
  input  sample_t   chip_left,
  input  sample_t   chip_right,
  output logic      mem_req,
  output mem_addr_t mem_addr,
  output logic      buf_half,
  output sample_t   pcm_left,   // Mixed words for the serial transmitter
  output sample_t   pcm_right,
  output logic      audio_l,
  output logic      audio_r
);

  logic    side_left;
  logic    pop_strobe;
  sample_t aux_left;
  sample_t aux_right;

  stream_fifo_if stream ();

  ////////////////////
  // Fetch path
  ////////////////////

  audio_stream_ctrl u_ctrl (
    .clk_114    (clk_114),
    .rst        (rst),
    .enable     (enable),
    .mem_ack    (mem_ack),
    .mem_fill   (mem_fill),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .buf_half   (buf_half),
    .side_left  (side_left),
    .pop_strobe (pop_strobe),
    .fifo       (stream.ctrl)
  );

  sample_stream_fifo u_fifo (
    .clk_114  (clk_114),
    .rst      (rst),
    .mem_fill (mem_fill),
    .mem_data (mem_data),
    .fifo     (stream.fifo)
  );

  ////////////////////
  // Audio path
  ////////////////////

  sample_unpack u_unpack (
    .clk_114    (clk_114),
    .rst        (rst),
    .enable     (enable),
    .pop_strobe (pop_strobe),
    .side_left  (side_left),
    .head       (stream.head),
    .aux_left   (aux_left),
    .aux_right  (aux_right)
  );

  audio_mixer u_mixer (
    .clk_114    (clk_114),
    .rst        (rst),
    .chip_left  (chip_left),
    .chip_right (chip_right),
    .aux_left   (aux_left),
    .aux_right  (aux_right),
    .mix_left   (pcm_left),
    .mix_right  (pcm_right)
  );

  sigma_delta_dac u_dac (
    .clk_114   (clk_114),
    .rst       (rst),
    .pcm_left  (pcm_left),
    .pcm_right (pcm_right),
    .audio_l   (audio_l),
    .audio_r   (audio_r)
  );

endmodule

// File: design/sample_stream_fifo.sv
`timescale 1ns/1ps

module sample_stream_fifo
  import aux_audio_pkg::*;
(
  input  logic        clk_114,
  input  logic        rst,
  input  logic        mem_fill,
  input  sample_t     mem_data,
  stream_fifo_if.fifo fifo
);

  sample_t            mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [LEVEL_W-1:0] count;

  // Storage
  always_ff @(posedge clk_114) begin
    if (mem_fill) begin
      mem[wr_ptr] <= mem_data;
    end
  end

  ////////////////////
  // Pointers and level
  ////////////////////

  always_ff @(posedge clk_114) begin
    if (rst || fifo.flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (mem_fill) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at FIFO_DEPTH
      end
      if (fifo.pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({mem_fill, fifo.pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign fifo.level = count;
  assign fifo.head  = mem[rd_ptr];  // Oldest word

endmodule

// File: design/sample_unpack.sv
`timescale 1ns/1ps

module sample_unpack
  import aux_audio_pkg::*;
(
  input  logic    clk_114,
  input  logic    rst,
  input  logic    enable,
  input  logic    pop_strobe,
  input  logic    side_left,
  input  sample_t head,
  output sample_t aux_left,
  output sample_t aux_right
);

  sample_t swapped;

  // Buffer words are stored little endian
  assign swapped = {head[7:0], head[15:8]};

  always_ff @(posedge clk_114) begin
    if (rst || !enable) begin
      aux_left  <= '0;
      aux_right <= '0;
    end else if (pop_strobe) begin
      if (side_left) begin
        aux_left <= swapped;
      end else begin
        aux_right <= swapped;
      end
    end
  end

endmodule

// File: design/sigma_delta_dac.sv
`timescale 1ns/1ps

module sigma_delta_dac
  import aux_audio_pkg::*;
(
  input  logic    clk_114,
  input  logic    rst,
  input  sample_t pcm_left,
  input  sample_t pcm_right,
  output logic    audio_l,
  output logic    audio_r
);

  logic [15:0] level [2];  // Offset binary per channel
  logic [15:0] acc [2];
  logic [1:0]  carry;

  // Sign flip turns two's complement into offset binary
  assign level[0] = {~pcm_left[15], pcm_left[14:0]};
  assign level[1] = {~pcm_right[15], pcm_right[14:0]};

  ////////////////////
  // First order loop
  ////////////////////

  // Carry density equals level / 65536
  always_ff @(posedge clk_114) begin
    if (rst) begin
      acc[0] <= '0;
      acc[1] <= '0;
      carry  <= '0;
    end else begin
      for (int ch = 0; ch < 2; ch++) begin
        {carry[ch], acc[ch]} <= {1'b0, acc[ch]} + {1'b0, level[ch]};
      end
    end
  end

  assign audio_l = carry[0];
  assign audio_r = carry[1];

endmodule

// File: design/stream_fifo_if.sv
`timescale 1ns/1ps

interface stream_fifo_if
  import aux_audio_pkg::*;
();

  logic               flush;  // Empty the FIFO this cycle
  logic               pop;    // Drop the head word
  logic [LEVEL_W-1:0] level;  // Words held
  sample_t            head;   // Oldest word

  modport ctrl (
    output flush,
    output pop,
    input  level
  );

  modport fifo (
    input  flush,
    input  pop,
    output level,
    output head
  );

endinterface

// File: filelist.f
design/aux_audio_pkg.sv
design/stream_fifo_if.sv
design/audio_stream_ctrl.sv
design/sample_stream_fifo.sv
design/sample_unpack.sv
design/audio_mixer.sv
design/sigma_delta_dac.sv
design/aux_audio_top.sv
tb/aux_audio_checker.sv
tb/aux_audio_tb.sv

// File: tb/aux_audio_checker.sv
`timescale 1ns/1ps

module aux_audio_checker
  import aux_audio_pkg::*;
(
  input logic               clk_114,
  input logic               rst,
  input logic               enable,
  input logic               mem_req,
  input logic               mem_ack,
  input logic               mem_fill,
  input logic               pop_strobe,
  input mem_addr_t          mem_addr,
  input logic [LEVEL_W-1:0] owed
);

  int                 fail_count = 0;  // Read by the testbench at the end
  logic [LEVEL_W-1:0] words_held;      // Fills minus pops since the last flush

  always_ff @(posedge clk_114) begin
    if (rst || !enable) begin
      words_held <= '0;  // FIFO flushed
    end else begin
      words_held <= words_held + LEVEL_W'(mem_fill) - LEVEL_W'(pop_strobe);
    end
  end

  // Request waits with a fixed address
  req_hold: assert property (@(posedge clk_114) disable iff (rst)
    mem_req && !mem_ack && enable |=> mem_req && $stable(mem_addr))
    else begin
      fail_count++;
      $error("mem_req or mem_addr changed before mem_ack");
    end

  req_drop: assert property (@(posedge clk_114) disable iff (rst)
    mem_req && mem_ack |=> !mem_req)  // One request per ack
    else begin
      fail_count++;
      $error("mem_req still high in the cycle after mem_ack");
    end

  fill_owed: assert property (@(posedge clk_114) disable iff (rst)
    mem_fill |-> owed != '0)
    else begin
      fail_count++;
      $error("mem_fill arrived with no word owed");
    end

  pop_level: assert property (@(posedge clk_114) disable iff (rst)
    pop_strobe |-> words_held != '0)
    else begin
      fail_count++;
      $error("pop_strobe with an empty FIFO");
    end

endmodule

bind audio_stream_ctrl aux_audio_checker u_checker (
  .clk_114    (clk_114),
  .rst        (rst),
  .enable     (enable),
  .mem_req    (mem_req),
  .mem_ack    (mem_ack),
  .mem_fill   (mem_fill),
  .pop_strobe (pop_strobe),
  .mem_addr   (mem_addr),
  .owed       (owed)
);

// File: tb/aux_audio_tb.sv
`timescale 1ns/1ps

module aux_audio_tb
  import aux_audio_pkg::*;
();

  typedef struct packed {
    logic    en;
    sample_t left;
    sample_t right;
    int      periods;
  } stim_row_t;

  localparam int NUM_ROWS   = 7;
  localparam int HALF_SP    = SAMPLE_PERIOD / 2;
  localparam int DAC_WINDOW = 65536;

  logic      clk_114    = 1'b0;
  logic      rst        = 1'b1;
  logic      enable     = 1'b0;
  logic      mem_ack    = 1'b0;
  logic      mem_fill   = 1'b0;
  sample_t   mem_data   = '0;
  sample_t   chip_left  = '0;
  sample_t   chip_right = '0;
  logic      mem_req;
  mem_addr_t mem_addr;
  logic      buf_half;
  sample_t   pcm_left;
  sample_t   pcm_right;
  logic      audio_l;
  logic      audio_r;

  stim_row_t            stim [NUM_ROWS];
  integer               seed          = 32'hf6d8_f2fa;
  int                   timeout_limit = 0;
  int                   cycle_cnt     = 0;
  sample_t              fifo_q [$];         // Words expected in the FIFO
  sample_t              held_left     = '0;
  sample_t              held_right    = '0;
  logic                 next_left     = 1'b1;
  logic                 enable_d      = 1'b0;
  int                   en_cnt        = 0;  // Enabled edges since enable rose
  logic [STREAM_AW-1:0] exp_offset    = '0;
  int                   fetch_errors  = 0;
  int                   req_errors    = 0;
  int                   pcm_errors    = 0;
  int                   dac_errors    = 0;

  aux_audio_top u_dut (.*);

  always #4 clk_114 = ~clk_114;

  // Buffer contents
  function automatic sample_t word_at(input mem_addr_t addr);
    return sample_t'(addr[15:0] ^ 16'h5a3c);
  endfunction

  function automatic sample_t saturate(input int sum);
    sample_t res;
    if (sum > 32767) begin
      res = 16'sh7fff;
    end else if (sum < -32768) begin
      res = 16'sh8000;
    end else begin
      res = sample_t'(sum);
    end
    return res;
  endfunction

  task automatic check_pcm();
    sample_t exp_l;
    sample_t exp_r;
    exp_l = saturate(int'(chip_left) + int'(held_left));
    exp_r = saturate(int'(chip_right) + int'(held_right));
    assert (pcm_left == exp_l && pcm_right == exp_r) else begin
      pcm_errors++;
      $display("[ERROR] %0t: pcm %0d/%0d, expected %0d/%0d",
               $time, pcm_left, pcm_right, exp_l, exp_r);
    end
  endtask

  task automatic check_density(input string name, input int ones, input sample_t pcm);
    int exp_ones;
    exp_ones = int'(pcm) + 32768;  // Offset binary
    assert (ones >= exp_ones - 1 && ones <= exp_ones + 1) else begin
      dac_errors++;
      $display("[ERROR] %0t: %s has %0d ones, expected %0d", $time, name, ones, exp_ones);
    end
  endtask

  always @(posedge clk_114) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_limit && timeout_limit > 0) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////
  // Memory model
  ////////////////////

  always begin : memory_model
    int        delay;
    int        gap;
    mem_addr_t addr;
    @(posedge clk_114);
    if (mem_req) begin
      delay = {$random(seed)} % 6;
      repeat (delay) @(posedge clk_114);
      if (mem_req) begin
        mem_ack <= 1'b1;
        @(posedge clk_114);
        mem_ack <= 1'b0;
        if (mem_req) begin  // Accepted at this edge
          addr = mem_addr;
          for (int i = 0; i < BURST_LEN; i++) begin
            gap = {$random(seed)} % 4;
            repeat (gap) @(posedge clk_114);
            mem_fill <= 1'b1;
            mem_data <= word_at(addr + mem_addr_t'(i));
            @(posedge clk_114);
            mem_fill <= 1'b0;
          end
        end
      end
    end
  end

  ////////////////////
  // Stream reference
  ////////////////////

  always @(posedge clk_114) begin : stream_monitor
    sample_t word;
    if (rst || !enable) begin
      fifo_q.delete();  // FIFO flushed
      held_left  = '0;
      held_right = '0;
      next_left  = 1'b1;
      en_cnt     = 0;
      exp_offset = '0;
      if (!rst && !enable_d) begin
        assert (!mem_req) else begin
          req_errors++;
          $display("[ERROR] %0t: mem_req high while disabled", $time);
        end
      end
    end else begin
      if (mem_req && mem_ack) begin
        assert (mem_addr == {AUD_BASE, exp_offset} && buf_half == exp_offset[STREAM_AW-1])
        else begin
          fetch_errors++;
          $display("[ERROR] %0t: fetch at %h half %b, expected %h",
                   $time, mem_addr, buf_half, {AUD_BASE, exp_offset});
        end
        exp_offset = exp_offset + STREAM_AW'(BURST_LEN);
      end
      en_cnt++;
      if (en_cnt % SAMPLE_PERIOD == 0 && fifo_q.size() > 0) begin
        word = fifo_q.pop_front();
        if (next_left) begin
          held_left = {word[7:0], word[15:8]};
        end else begin
          held_right = {word[7:0], word[15:8]};
        end
        next_left = ~next_left;  // Empty tick keeps the side
      end
      if (mem_fill) begin
        fifo_q.push_back(mem_data);
      end
    end
    enable_d = enable;
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    int total_periods;
    int ones_l;
    int ones_r;
    int checker_fails;
    stim[0] = '{1'b0, 16'sd100, -16'sd200, 1};      // Chip audio only
    stim[1] = '{1'b1, 16'sd0, 16'sd0, 40};
    stim[2] = '{1'b1, 16'sh7000, 16'sh7000, 4};     // Positive overflow
    stim[3] = '{1'b1, 16'sd0, 16'sd0, 90};          // Offsets pass 128, samples turn negative
    stim[4] = '{1'b1, -16'sh7000, -16'sh7000, 4};   // Negative overflow
    stim[5] = '{1'b0, 16'sd1234, -16'sd4321, 2};
    stim[6] = '{1'b1, 16'sd0, 16'sd0, 6};           // Fetch restarts at offset 0
    total_periods = 0;
    foreach (stim[r]) begin
      total_periods += stim[r].periods;
    end
    timeout_limit = total_periods * SAMPLE_PERIOD + 70000 + 10000;
    repeat (4) @(posedge clk_114);
    rst <= 1'b0;
    foreach (stim[r]) begin
      enable     <= stim[r].en;
      chip_left  <= stim[r].left;
      chip_right <= stim[r].right;
      for (int p = 0; p < stim[r].periods; p++) begin
        repeat (HALF_SP) @(posedge clk_114);
        check_pcm();  // Midway between pops
        repeat (SAMPLE_PERIOD - HALF_SP) @(posedge clk_114);
      end
    end
    enable     <= 1'b0;
    chip_left  <= 16'sh2000;
    chip_right <= -16'sh3000;
    repeat (8) @(posedge clk_114);
    ones_l = 0;
    ones_r = 0;
    repeat (DAC_WINDOW) begin
      @(posedge clk_114);
      ones_l += int'(audio_l);
      ones_r += int'(audio_r);
    end
    check_density("audio_l", ones_l, chip_left);
    check_density("audio_r", ones_r, chip_right);
    checker_fails = u_dut.u_ctrl.u_checker.fail_count;
    $display("Errors: fetch %0d, request %0d, pcm %0d, density %0d, checker %0d",
             fetch_errors, req_errors, pcm_errors, dac_errors, checker_fails);
    if (fetch_errors + req_errors + pcm_errors + dac_errors + checker_fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
